// File: logic/rtg_consts.svh
/*
 * Widths and fixed values for the RTG display back end.
 * Included by the package and by every RTL file that sizes a port
 * or a register from these macros.
 */
`ifndef RTG_CONSTS_SVH
`define RTG_CONSTS_SVH

// Fetched word from the pixel stream
`define RTG_WORD_W 16

// One colour channel
`define RTG_CHAN_W 8

`define RTG_PW_W 4          // Clocks-per-fetch field
`define RTG_VB_W 7          // Vblank extension in hsyncs

`define CLUT_AW 8           // 256 palette entries
`define NATIVE_STROBE_W 3   // Native pixel strobe divider

`endif

// File: logic/rtg_pkg.sv
/*
 * Shared types for the RTG display back end.
 * Holds the format and vblank state enums plus the packed structs
 * that carry mode, chipset video, control strobes and palette writes.
 */
`include "rtg_consts.svh"

package rtg_pkg;

	// Pixel format opcode
	typedef enum logic [1:0] {
		FMT_RGB15 = 2'd0,   // x:5:5:5
		FMT_RGB16 = 2'd1,   // 5:6:5
		FMT_CLUT8 = 2'd2    // Two 8-bit indices per word
	} pix_fmt_e;

	// Vblank extender
	typedef enum logic [1:0] {
		VB_CHIP   = 2'd0,   // Chipset vblank still high
		VB_EXTEND = 2'd1,   // Counting hsyncs
		VB_ACTIVE = 2'd2
	} vb_state_e;

	typedef struct packed {
		logic [`RTG_CHAN_W-1:0] r;
		logic [`RTG_CHAN_W-1:0] g;
		logic [`RTG_CHAN_W-1:0] b;
	} rgb_t;

	// Register image from system software
	typedef struct packed {
		logic                 ena;
		pix_fmt_e             fmt;
		logic [`RTG_PW_W-1:0] pixel_width;   // Clocks per fetch minus one
		logic [`RTG_VB_W-1:0] vbend;         // Extra blank lines
	} rtg_mode_t;

	typedef struct packed {
		rgb_t rgb;
		logic hs;
		logic vs;
		logic cs;
	} chip_video_t;

	// Control to datapath
	typedef struct packed {
		logic word_load;    // Capture fetched word
		logic clut_lo;      // Low byte as index
		logic active;       // Non-blank two clocks late
		logic rtg_on;
		logic pixel;        // RTG pixel strobe
	} pix_ctrl_t;

	typedef struct packed {
		logic                we;
		logic [`CLUT_AW-1:0] addr;
		rgb_t                data;
	} clut_wr_t;

endpackage

// File: logic/rtg_timing_ctrl.sv
/*
 * RTG display timing.
 * Runs the per-pixel fetch counter, the mid-period CLUT byte select,
 * the blank delay pipeline and the vblank extender. Issues the stream
 * advance pulse and the pixel strobe for both RTG and native video.
 */
`timescale 1ns/1ps
`include "rtg_consts.svh"

module rtg_timing_ctrl (
	input  logic               CLK_114,
	input  logic               rst_n,
	input  rtg_pkg::rtg_mode_t mode,
	input  logic               hblank,
	input  logic               vblank,
	input  logic               chip_hs,
	input  logic               scan_15khz,
	output logic               pix_req,
	output logic               vga_pixel,
	output rtg_pkg::pix_ctrl_t pix_ctrl
);
	import rtg_pkg::*;

	logic [`RTG_PW_W-1:0]        pix_ctr;      // Compared against pixel_width
	logic [`RTG_PW_W-1:0]        half_width;
	logic                        clut_sel;     // Second byte of the word
	logic                        clut_sel_d;
	logic                        pix_req_d;
	logic                        blank;
	logic                        blank_d;
	logic                        blank_d2;
	vb_state_e                   vb_state;
	logic [`RTG_VB_W-1:0]        vb_ctr;       // Hsyncs since chipset vblank
	logic                        hs_d;
	logic                        hs_rise;
	logic                        rtg_vblank;
	logic [`NATIVE_STROBE_W-1:0] native_ctr;
	logic [`NATIVE_STROBE_W-1:0] native_step;
	logic                        native_strobe;
	logic                        rtg_strobe;

	////////////////////
	// Fetch timing

	assign half_width = {1'b0, mode.pixel_width[`RTG_PW_W-1:1]};
	assign blank      = rtg_vblank | hblank;
	assign pix_req    = mode.ena && !blank && (pix_ctr == mode.pixel_width);

	always_ff @(posedge CLK_114) begin
		if (!rst_n) begin
			pix_ctr    <= '0;
			clut_sel   <= 1'b0;
			clut_sel_d <= 1'b0;
			pix_req_d  <= 1'b0;
			blank_d    <= 1'b1;
			blank_d2   <= 1'b1;
		end else begin
			pix_req_d  <= pix_req;
			clut_sel_d <= clut_sel;
			blank_d    <= blank;      // Matches the word and CLUT latency
			blank_d2   <= blank_d;
			if (pix_ctr == half_width)
				clut_sel <= 1'b1;     // Halfway through the fetch period
			if (blank || pix_req) begin
				pix_ctr  <= '0;
				clut_sel <= 1'b0;
			end else begin
				pix_ctr <= pix_ctr + 1'b1;
			end
		end
	end

	////////////////////
	// Vblank extender

	assign hs_rise    = chip_hs & !hs_d;
	assign rtg_vblank = vblank | (vb_state != VB_ACTIVE);

	always_ff @(posedge CLK_114) begin
		if (!rst_n) begin
			vb_state <= VB_CHIP;
			vb_ctr   <= '0;
			hs_d     <= 1'b0;
		end else begin
			hs_d <= chip_hs;
			case (vb_state)
				VB_CHIP: begin
					vb_ctr <= '0;
					if (!vblank)
						vb_state <= VB_EXTEND;
				end
				VB_EXTEND: begin
					if (vblank)
						vb_state <= VB_CHIP;
					else if (vb_ctr == mode.vbend)
						vb_state <= VB_ACTIVE;
					else if (hs_rise)
						vb_ctr <= vb_ctr + 1'b1;   // One more line hidden
				end
				VB_ACTIVE: begin
					if (vblank)
						vb_state <= VB_CHIP;
				end
				default: vb_state <= VB_CHIP;
			endcase
		end
	end

	////////////////////
	// Pixel strobes

	// Step by 2 in 15 kHz mode so the period halves
	assign native_step   = {{(`NATIVE_STROBE_W-2){1'b0}}, scan_15khz, !scan_15khz};
	assign native_strobe = (native_ctr == '0);

	always_ff @(posedge CLK_114) begin
		if (!rst_n)
			native_ctr <= '0;
		else
			native_ctr <= {native_ctr[`NATIVE_STROBE_W-1:1], native_ctr[0] & !scan_15khz}
				+ native_step;
	end

	// Second pulse per word on the low-byte index in CLUT mode
	assign rtg_strobe = pix_req_d | (clut_sel & !clut_sel_d & (mode.fmt == FMT_CLUT8));

	assign pix_ctrl.word_load = pix_req;
	assign pix_ctrl.clut_lo   = clut_sel;
	assign pix_ctrl.active    = !blank_d2;
	assign pix_ctrl.rtg_on    = mode.ena;
	assign pix_ctrl.pixel     = rtg_strobe;

	assign vga_pixel = pix_ctrl.rtg_on ? pix_ctrl.pixel : native_strobe;

endmodule

// File: logic/rtg_clut.sv
/*
 * 256-entry palette RAM for 8-bit indexed RTG modes.
 * One write port for the system software and a registered read port
 * addressed by the pixel decoder. Maps onto a block RAM.
 */
`timescale 1ns/1ps
`include "rtg_consts.svh"

module rtg_clut (
	input  logic                CLK_114,
	input  rtg_pkg::clut_wr_t   wr,
	input  logic [`CLUT_AW-1:0] rd_addr,
	output rtg_pkg::rgb_t       rd_rgb
);
	import rtg_pkg::*;

	// One 24-bit colour per index
	rgb_t palette [0:(1 << `CLUT_AW)-1];

	////////////////////
	// Write port

	always_ff @(posedge CLK_114) begin
		if (wr.we)
			palette[wr.addr] <= wr.data;
	end

	////////////////////
	// Read port

	// One clock from index to colour
	always_ff @(posedge CLK_114) begin
		rd_rgb <= palette[rd_addr];   // Old data on a same-address write
	end

endmodule

// File: logic/rtg_pixel_decode.sv
/*
 * RTG pixel word decoder.
 * Captures the fetched word on each advance pulse and expands it to
 * 24-bit RGB. In 8-bit mode it drives the palette index instead, high
 * byte first, and forwards the palette colour.
 */
`timescale 1ns/1ps
`include "rtg_consts.svh"

module rtg_pixel_decode (
	input  logic                   CLK_114,
	input  logic                   rst_n,
	input  rtg_pkg::pix_fmt_e      fmt,
	input  rtg_pkg::pix_ctrl_t     pix_ctrl,
	input  logic [`RTG_WORD_W-1:0] pix_data,
	output logic [`CLUT_AW-1:0]    clut_addr,
	input  rtg_pkg::rgb_t          clut_rgb,
	output rtg_pkg::rgb_t          rgb
);
	import rtg_pkg::*;

	logic [`RTG_WORD_W-1:0] pix_word;   // Current fetched word
	rgb_t                   hc15;
	rgb_t                   hc16;

	always_ff @(posedge CLK_114) begin
		if (!rst_n)
			pix_word <= '0;
		else if (pix_ctrl.word_load)
			pix_word <= pix_data;       // Head of the stream
	end

	////////////////////
	// High colour

	// Top bits replicated into the low bits so full scale stays full
	assign hc15.r = {pix_word[14:10], pix_word[14:12]};
	assign hc15.g = {pix_word[9:5], pix_word[9:7]};
	assign hc15.b = {pix_word[4:0], pix_word[4:2]};

	assign hc16.r = {pix_word[15:11], pix_word[15:13]};
	assign hc16.g = {pix_word[10:5], pix_word[10:9]};   // Six bits of green
	assign hc16.b = hc15.b;

	////////////////////
	// Indexed

	assign clut_addr = pix_ctrl.clut_lo ? pix_word[`CLUT_AW-1:0]
		: pix_word[`RTG_WORD_W-1 -: `CLUT_AW];

	always_comb begin
		case (fmt)
			FMT_RGB15: rgb = hc15;
			FMT_RGB16: rgb = hc16;
			FMT_CLUT8: rgb = clut_rgb;    // Already one clock later
			default:   rgb = hc16;
		endcase
	end

endmodule

// File: logic/video_out_mux.sv
/*
 * Final video output stage.
 * Picks chipset or RTG colour, blacks out RTG blank, draws the OSD
 * window over the top bits of each channel and applies sync polarity
 * and inversion. All VGA outputs leave from one register.
 */
`timescale 1ns/1ps
`include "rtg_consts.svh"

module video_out_mux (
	input  logic                 CLK_114,
	input  logic                 rst_n,
	input  rtg_pkg::pix_ctrl_t   pix_ctrl,
	input  rtg_pkg::rgb_t        rtg_rgb,
	input  rtg_pkg::chip_video_t chip,
	input  logic                 osd_window,
	input  logic                 osd_pixel,
	input  logic                 hsync_pol,
	input  logic                 vsync_pol,
	input  logic                 invert_sync,
	output rtg_pkg::chip_video_t vga
);
	import rtg_pkg::*;

	rgb_t        base_rgb;
	rgb_t        over_rgb;
	chip_video_t vga_next;
	logic [1:0]  osd_rg;      // Red and green OSD bits
	logic [1:0]  osd_b;
	logic        sync_flip;

	////////////////////
	// Colour select

	always_comb begin
		if (pix_ctrl.rtg_on)
			base_rgb = pix_ctrl.active ? rtg_rgb : '0;   // Black in blank
		else
			base_rgb = chip.rgb;
	end

	// OSD text white, background dark blue
	assign osd_rg = osd_pixel ? 2'b11 : 2'b00;
	assign osd_b  = osd_pixel ? 2'b11 : 2'b10;

	// Underlying picture dimmed into the low six bits
	assign over_rgb.r = {osd_rg, base_rgb.r[`RTG_CHAN_W-1:2]};
	assign over_rgb.g = {osd_rg, base_rgb.g[`RTG_CHAN_W-1:2]};
	assign over_rgb.b = {osd_b, base_rgb.b[`RTG_CHAN_W-1:2]};

	////////////////////
	// Syncs

	// Inversion only for native video
	assign sync_flip = invert_sync & !pix_ctrl.rtg_on;

	assign vga_next.rgb = osd_window ? over_rgb : base_rgb;
	assign vga_next.hs  = chip.hs ^ hsync_pol ^ sync_flip;
	assign vga_next.vs  = chip.vs ^ vsync_pol ^ sync_flip;
	assign vga_next.cs  = chip.cs;

	always_ff @(posedge CLK_114) begin
		if (!rst_n)
			vga <= '0;
		else
			vga <= vga_next;
	end

endmodule

// File: logic/rtg_video_top.sv
/*
 * RTG display back end top level.
 * Connects timing control, word decoder, palette RAM and output mux.
 * The pixel stream is external: pix_data holds the head word and
 * pix_req advances it by one.
 */
`timescale 1ns/1ps
`include "rtg_consts.svh"

module rtg_video_top (
	input  logic                   CLK_114,
	input  logic                   rst_n,
	input  rtg_pkg::rtg_mode_t     mode,
	input  logic [`RTG_WORD_W-1:0] pix_data,
	input  rtg_pkg::chip_video_t   chip,
	input  logic                   hblank,
	input  logic                   vblank,
	input  logic                   osd_window,
	input  logic                   osd_pixel,
	input  logic                   hsync_pol,
	input  logic                   vsync_pol,
	input  logic                   invert_sync,
	input  logic                   scan_15khz,
	input  rtg_pkg::clut_wr_t      clut_wr,
	output logic                   pix_req,
	output rtg_pkg::chip_video_t   vga,
	output logic                   vga_pixel
);
	import rtg_pkg::*;

	pix_ctrl_t           pix_ctrl;
	logic [`CLUT_AW-1:0] clut_addr;
	rgb_t                clut_rgb;
	rgb_t                rtg_rgb;   // Decoded colour into the mux

	rtg_timing_ctrl u_timing (
		.CLK_114    (CLK_114),
		.rst_n      (rst_n),
		.mode       (mode),
		.hblank     (hblank),
		.vblank     (vblank),
		.chip_hs    (chip.hs),       // Counted for the vblank extension
		.scan_15khz (scan_15khz),
		.pix_req    (pix_req),
		.vga_pixel  (vga_pixel),
		.pix_ctrl   (pix_ctrl)
	);

	rtg_pixel_decode u_decode (
		.CLK_114   (CLK_114),
		.rst_n     (rst_n),
		.fmt       (mode.fmt),
		.pix_ctrl  (pix_ctrl),
		.pix_data  (pix_data),
		.clut_addr (clut_addr),
		.clut_rgb  (clut_rgb),
		.rgb       (rtg_rgb)
	);

	rtg_clut u_clut (
		.CLK_114 (CLK_114),
		.wr      (clut_wr),
		.rd_addr (clut_addr),
		.rd_rgb  (clut_rgb)
	);

	video_out_mux u_out_mux (
		.CLK_114     (CLK_114),
		.rst_n       (rst_n),
		.pix_ctrl    (pix_ctrl),
		.rtg_rgb     (rtg_rgb),
		.chip        (chip),
		.osd_window  (osd_window),
		.osd_pixel   (osd_pixel),
		.hsync_pol   (hsync_pol),
		.vsync_pol   (vsync_pol),
		.invert_sync (invert_sync),
		.vga         (vga)
	);

endmodule

// File: tb/tb_rtg_video.sv
/*
 * Directed testbench for the RTG display back end.
 * Each test is a task that drives rtg_video_top and checks vga,
 * pix_req and vga_pixel against values worked out from the fetch,
 * decode and output rules. Built through vlog.f by the Makefile.
 */
`timescale 1ns/1ps
`include "rtg_consts.svh"

module tb_rtg_video;
	import rtg_pkg::*;

	localparam int CLK_PERIOD   = 8;
	localparam int RESET_CYCLES = 8;
	localparam int N_WORDS      = 16;
	localparam int STROBE_LIMIT = 64;   // Longest legal wait for any strobe

	// Cycle budget per test for the watchdog
	localparam int T_FETCH    = 3 * (4 + 20 + 3 * 8);
	localparam int T_HICOL    = 2 * (20 + N_WORDS * 8);
	localparam int T_CLUT     = 256 + 20 + N_WORDS * 9;
	localparam int T_VBLANK   = 20 + 5 * 10 + 20;
	localparam int T_NATIVE   = 32 * 3 + 4 * 12;
	localparam int MARGIN     = 1000;
	localparam int WATCHDOG_NS = (RESET_CYCLES + T_FETCH + T_HICOL + T_CLUT + T_VBLANK
		+ T_NATIVE + MARGIN) * CLK_PERIOD;

	logic                   CLK_114;
	logic                   rst_n;
	rtg_mode_t              mode;
	logic [`RTG_WORD_W-1:0] pix_data;
	chip_video_t            chip;
	logic                   hblank;
	logic                   vblank;
	logic                   osd_window;
	logic                   osd_pixel;
	logic                   hsync_pol;
	logic                   vsync_pol;
	logic                   invert_sync;
	logic                   scan_15khz;
	clut_wr_t               clut_wr;
	logic                   pix_req;
	chip_video_t            vga;
	logic                   vga_pixel;

	logic [31:0] lcg_state;
	int          checks_done;
	rgb_t        palette_model [0:255];   // What the palette should hold

	rtg_video_top u_rtg_video_top (
		.CLK_114     (CLK_114),
		.rst_n       (rst_n),
		.mode        (mode),
		.pix_data    (pix_data),
		.chip        (chip),
		.hblank      (hblank),
		.vblank      (vblank),
		.osd_window  (osd_window),
		.osd_pixel   (osd_pixel),
		.hsync_pol   (hsync_pol),
		.vsync_pol   (vsync_pol),
		.invert_sync (invert_sync),
		.scan_15khz  (scan_15khz),
		.clut_wr     (clut_wr),
		.pix_req     (pix_req),
		.vga         (vga),
		.vga_pixel   (vga_pixel)
	);

	initial begin
		CLK_114 = 1'b0;
		forever #(CLK_PERIOD / 2) CLK_114 = ~CLK_114;
	end

	initial begin
		#(WATCHDOG_NS);
		abort_run("Timeout, the tests did not finish within the watchdog limit");
	end

	////////////////////
	// Helpers

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("=== FAIL ===");
		$fatal(1, "Run aborted");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks_done++;
		if (expected !== actual)
			abort_run($sformatf("Mismatch %s exp=0x%0h got=0x%0h", name, expected, actual));
	endtask

	// Upper half of a 32-bit LCG state
	function automatic logic [15:0] rand16();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[31:16];
	endfunction

	function automatic logic strobe_level(input bit use_pixel);
		return use_pixel ? vga_pixel : pix_req;
	endfunction

	// Returns at the negedge where the strobe is seen high
	task automatic wait_strobe(input bit use_pixel, input string what);
		int n;
		n = 0;
		@(negedge CLK_114);
		while (!strobe_level(use_pixel)) begin
			n++;
			if (n > STROBE_LIMIT)
				abort_run($sformatf("No %s pulse within %0d clocks", what, STROBE_LIMIT));
			@(negedge CLK_114);
		end
	endtask

	// Call right after a strobe was seen
	task automatic check_gap(input bit use_pixel, input string what, input int exp_gap);
		int gap;
		gap = 0;
		do begin
			@(negedge CLK_114);
			gap++;
		end while (!strobe_level(use_pixel) && gap <= STROBE_LIMIT);
		check_value({what, " gap"}, exp_gap, gap);
	endtask

	// Top bits copied into the low bits of each channel
	function automatic rgb_t expand_hicolour(input pix_fmt_e fmt, input logic [15:0] w);
		logic [4:0] r5;
		logic [4:0] g5;
		logic [5:0] g6;
		logic [4:0] b5;
		rgb_t       c;
		b5 = w[4:0];
		if (fmt == FMT_RGB15) begin
			r5 = w[14:10];
			g5 = w[9:5];
			c.g = {g5, g5[4:2]};
		end else begin
			r5 = w[15:11];
			g6 = w[10:5];
			c.g = {g6, g6[5:4]};
		end
		c.r = {r5, r5[4:2]};
		c.b = {b5, b5[4:2]};
		return c;
	endfunction

	function automatic rgb_t osd_overlay(input rgb_t base, input logic pixel);
		logic [1:0] top_rg;
		logic [1:0] top_b;
		rgb_t       c;
		top_rg = pixel ? 2'b11 : 2'b00;
		top_b  = pixel ? 2'b11 : 2'b10;   // Dark blue background
		c.r = {top_rg, base.r[7:2]};
		c.g = {top_rg, base.g[7:2]};
		c.b = {top_b, base.b[7:2]};
		return c;
	endfunction

	////////////////////
	// Tests

	task automatic test_fetch_spacing();
		logic [3:0] widths [3];
		int         i;
		widths[0] = 4'd1;
		widths[1] = 4'd3;
		widths[2] = 4'd7;
		repeat (4) begin
			@(negedge CLK_114);
			check_value("pix_req", 0, pix_req);   // Still idle after reset
			check_value("vga", 0, vga);
		end
		for (i = 0; i < 3; i++) begin
			@(posedge CLK_114);
			hblank           <= 1'b1;   // Clears the fetch counter
			vblank           <= 1'b0;
			mode.ena         <= 1'b1;
			mode.fmt         <= FMT_RGB16;
			mode.pixel_width <= widths[i];
			mode.vbend       <= '0;
			@(posedge CLK_114);
			hblank <= 1'b0;
			wait_strobe(1'b0, "pix_req");
			repeat (3)
				check_gap(1'b0, "pix_req", int'(widths[i]) + 1);
		end
	endtask

	task automatic test_hicolour();
		pix_fmt_e    fmts [2];
		logic [15:0] w;
		logic [15:0] w_next;
		int          f;
		fmts[0] = FMT_RGB15;
		fmts[1] = FMT_RGB16;
		for (f = 0; f < 2; f++) begin
			w = rand16();
			@(posedge CLK_114);
			mode.fmt         <= fmts[f];
			mode.pixel_width <= 4'd3;
			pix_data         <= w;
			repeat (N_WORDS) begin
				wait_strobe(1'b0, "pix_req");
				w_next = rand16();
				@(posedge CLK_114);
				pix_data <= w_next;   // Stream head moves on after the fetch
				@(negedge CLK_114);
				check_value("vga_pixel", 1, vga_pixel);
				@(negedge CLK_114);   // Word register then output register
				check_value("vga.rgb", expand_hicolour(fmts[f], w), vga.rgb);
				w = w_next;
			end
		end
	endtask

	task automatic test_clut();
		logic [15:0] w;
		logic [15:0] w_next;
		logic [15:0] ra;
		logic [15:0] rb;
		rgb_t        entry;
		int          a;
		for (a = 0; a < 256; a++) begin
			ra = rand16();
			rb = rand16();
			entry = {ra, rb[7:0]};
			palette_model[a] = entry;
			@(posedge CLK_114);
			clut_wr.we   <= 1'b1;
			clut_wr.addr <= a[7:0];
			clut_wr.data <= entry;
		end
		w = rand16();
		@(posedge CLK_114);
		clut_wr.we       <= 1'b0;
		mode.fmt         <= FMT_CLUT8;
		mode.pixel_width <= 4'd7;   // Low byte selected 4 clocks into the period
		pix_data         <= w;
		repeat (N_WORDS) begin
			wait_strobe(1'b0, "pix_req");
			w_next = rand16();
			@(posedge CLK_114);
			pix_data <= w_next;
			@(negedge CLK_114);
			check_value("vga_pixel", 1, vga_pixel);
			repeat (2) @(negedge CLK_114);   // Extra clock for the RAM read
			check_value("vga.rgb", palette_model[w[15:8]], vga.rgb);
			repeat (2) @(negedge CLK_114);
			check_value("vga_pixel", 1, vga_pixel);   // Low byte strobe
			repeat (2) @(negedge CLK_114);
			check_value("vga.rgb", palette_model[w[7:0]], vga.rgb);
			w = w_next;
		end
	endtask

	// One line with its hsync while pix_req stays low
	task automatic drive_hsync_line(input bit last);
		int k;
		@(posedge CLK_114);
		chip.hs <= 1'b1;
		@(negedge CLK_114);
		check_value("pix_req", 0, pix_req);   // Edge not counted yet
		if (!last) begin
			for (k = 0; k < 8; k++) begin
				@(posedge CLK_114);
				chip.hs <= (k < 2);   // Sync three clocks wide
				@(negedge CLK_114);
				check_value("pix_req", 0, pix_req);
			end
		end
	endtask

	task automatic test_vblank_extend();
		logic [6:0] lines;
		int         n;
		lines = 7'd5;
		@(posedge CLK_114);
		mode.fmt         <= FMT_RGB16;
		mode.pixel_width <= 4'd1;
		mode.vbend       <= lines;
		vblank           <= 1'b1;
		chip.hs          <= 1'b0;
		repeat (6) begin
			@(negedge CLK_114);
			check_value("pix_req", 0, pix_req);
		end
		@(posedge CLK_114);
		vblank <= 1'b0;
		repeat (6) begin
			@(negedge CLK_114);
			check_value("pix_req", 0, pix_req);   // Extension running
		end
		for (n = 0; n < int'(lines); n++)
			drive_hsync_line(n == int'(lines) - 1);
		wait_strobe(1'b0, "pix_req");
		check_gap(1'b0, "pix_req", 2);
		@(posedge CLK_114);
		chip.hs <= 1'b0;
	endtask

	task automatic test_native_out();
		logic [15:0] ra;
		logic [15:0] rb;
		chip_video_t c;
		logic        rtg;
		int          i;
		for (i = 0; i < 32; i++) begin
			ra = rand16();
			rb = rand16();
			c.rgb = {ra, rb[7:0]};
			c.hs  = rb[8];
			c.vs  = rb[9];
			c.cs  = rb[10];
			rtg   = (i % 4 == 3);   // RTG on in every fourth vector
			@(posedge CLK_114);
			chip        <= c;
			hsync_pol   <= rb[11];
			vsync_pol   <= rb[12];
			invert_sync <= rb[13];
			osd_window  <= rb[14];
			osd_pixel   <= rb[15];
			mode.ena    <= rtg;
			repeat (2) @(negedge CLK_114);   // Through the output register
			check_value("vga.hs", c.hs ^ rb[11] ^ (rb[13] & !rtg), vga.hs);
			check_value("vga.vs", c.vs ^ rb[12] ^ (rb[13] & !rtg), vga.vs);
			check_value("vga.cs", c.cs, vga.cs);
			if (!rtg)
				check_value("vga.rgb", rb[14] ? osd_overlay(c.rgb, rb[15]) : c.rgb, vga.rgb);
		end
		@(posedge CLK_114);
		mode.ena   <= 1'b0;
		osd_window <= 1'b0;
		scan_15khz <= 1'b0;
		wait_strobe(1'b1, "vga_pixel");
		repeat (2) check_gap(1'b1, "vga_pixel", 8);
		@(posedge CLK_114);
		scan_15khz <= 1'b1;   // Half period
		wait_strobe(1'b1, "vga_pixel");
		repeat (2) check_gap(1'b1, "vga_pixel", 4);
	endtask

	////////////////////
	// Main sequence

	initial begin
		lcg_state   = 32'd14104;
		checks_done = 0;
		rst_n       = 1'b0;
		mode        = '0;
		pix_data    = '0;
		chip        = '0;
		hblank      = 1'b0;
		vblank      = 1'b1;   // Frame starts in chipset vblank
		osd_window  = 1'b0;
		osd_pixel   = 1'b0;
		hsync_pol   = 1'b0;
		vsync_pol   = 1'b0;
		invert_sync = 1'b0;
		scan_15khz  = 1'b0;
		clut_wr     = '0;
		repeat (RESET_CYCLES) @(posedge CLK_114);
		rst_n <= 1'b1;

		test_fetch_spacing();
		test_hicolour();
		test_clut();
		test_vblank_extend();
		test_native_out();

		if (checks_done > 0) begin
			$display("=== PASS ===");
			$finish;
		end else begin
			abort_run("No checks were run");
		end
	end

endmodule

// File: vlog.f
+incdir+logic
logic/rtg_pkg.sv
logic/rtg_timing_ctrl.sv
logic/rtg_clut.sv
logic/rtg_pixel_decode.sv
logic/video_out_mux.sv
logic/rtg_video_top.sv
tb/tb_rtg_video.sv

// File: Makefile
# Verilator build and run for the RTG display back end testbench.
# Any variable below can be overridden on the command line.

VERILATOR ?= verilator
TOP       ?= tb_rtg_video
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= === PASS ===

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run $(TOP), search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q -- "$(PASS_MSG)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
